//--- build.f
hw/renkon_pkg.sv
hw/mem_sp.sv
hw/renkon_linebuf.sv
hw/renkon_conv.sv
hw/renkon_top.sv
test/renkon_asserts.sv
test/renkon_tb.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run, then search the log for the result.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module renkon_tb -f build.f \
  -o renkon_sim && ./obj_dir/renkon_sim > sim.log 2>&1
grep -q "STATUS: PASS" sim.log 2>/dev/null && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- test/renkon_tb.sv
`timescale 1ns/100ps

module renkon_tb;

  localparam int FRAME_LIMIT = 2000;
  localparam int M = renkon_pkg::MAXLINE;

  logic                clk;
  logic                xrst;
  logic                frame_start;
  renkon_pkg::size_t   img_size;
  renkon_pkg::size_t   fil_size;
  renkon_pkg::pixel_t  pixel_in;
  logic                w_we;
  logic [4:0]          w_addr;
  renkon_pkg::weight_t w_data;
  renkon_pkg::sum_t    conv_out;
  logic                conv_valid;
  logic                frame_done;

  renkon_pkg::pixel_t  img [renkon_pkg::MAXSIZE*renkon_pkg::MAXSIZE];
  renkon_pkg::weight_t ker [renkon_pkg::NTAP];
  renkon_pkg::sum_t    results [$];

  renkon_top dut (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic stop_with_error(string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic compare_sum(string name, renkon_pkg::sum_t got, renkon_pkg::sum_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic compare_count(int got, int exp);
    if (got < exp) begin
      stop_with_error($sformatf("missing results: %0d received, %0d expected", got, exp));
    end else if (got > exp) begin
      stop_with_error($sformatf("extra results: %0d received, %0d expected", got, exp));
    end
  endtask

  // --------------------
  // reference model.
  // --------------------
  function automatic renkon_pkg::sum_t ref_conv(int n, int f, int y, int x);
    renkon_pkg::sum_t acc;
    acc = '0;
    for (int r = 0; r < f; r++) begin
      for (int c = 0; c < f; c++) begin
        acc += renkon_pkg::sum_t'(img[(y+r)*n+x+c]) * renkon_pkg::sum_t'(ker[r*M+c]);
      end
    end
    return acc;
  endfunction

  function automatic void random_image(int n);
    for (int i = 0; i < n*n; i++) begin
      img[i] = renkon_pkg::pixel_t'($urandom);
    end
  endfunction

  // zero outside the filter.
  function automatic void random_kernel(int f);
    for (int i = 0; i < renkon_pkg::NTAP; i++) begin
      ker[i] = (i / M < f && i % M < f) ? renkon_pkg::weight_t'($urandom) : '0;
    end
  endfunction

  task automatic write_kernel();
    for (int i = 0; i < renkon_pkg::NTAP; i++) begin
      @(negedge clk);
      w_we   = 1'b1;
      w_addr = 5'(i);
      w_data = ker[i];
    end
    @(negedge clk);
    w_we = 1'b0;
  endtask

  // --------------------
  // frame driver.
  // --------------------
  task automatic run_frame(int n, int f);
    int cycles;
    int tail;
    int m;
    m = n - f + 1;
    results.delete();
    @(negedge clk);
    img_size    = renkon_pkg::size_t'(n);
    fil_size    = renkon_pkg::size_t'(f);
    frame_start = 1'b1;
    pixel_in    = img[0];
    cycles = 0;
    tail   = -1;
    // last result lands 2 cycles after frame_done.
    while (tail != 0) begin
      @(negedge clk);
      if (conv_valid) begin
        results.push_back(conv_out);
      end
      if (tail > 0) begin
        tail--;
      end else if (tail < 0 && frame_done) begin
        tail = 2;
      end
      frame_start = 1'b0;
      cycles++;
      pixel_in = (cycles < n*n) ? img[cycles] : '0;
      if (cycles > FRAME_LIMIT) begin
        stop_with_error("timeout while waiting for frame_done");
      end
    end
    compare_count(results.size(), m*m);
    for (int i = 0; i < m*m; i++) begin
      compare_sum($sformatf("conv_out at y=%0d x=%0d", i / m, i % m),
                  results[i], ref_conv(n, f, i / m, i % m));
    end
  endtask

  // --------------------
  // tests.
  // --------------------
  task automatic identity_kernel();
    random_kernel(0);
    ker[M+1] = renkon_pkg::weight_t'(1);
    write_kernel();
    random_image(8);
    run_frame(8, 3);
  endtask

  task automatic random_3x3();
    random_kernel(3);
    write_kernel();
    random_image(10);
    run_frame(10, 3);
  endtask

  task automatic extreme_5x5();
    for (int i = 0; i < renkon_pkg::NTAP; i++) begin
      ker[i] = ($urandom % 2 == 0) ? renkon_pkg::weight_t'(8'h7f) : renkon_pkg::weight_t'(8'h80);
    end
    write_kernel();
    for (int i = 0; i < 144; i++) begin
      img[i] = ($urandom % 2 == 0) ? renkon_pkg::pixel_t'(16'h7fff)
                                   : renkon_pkg::pixel_t'(16'h8000);
    end
    run_frame(12, 5);
  endtask

  task automatic back_to_back();
    random_kernel(3);
    write_kernel();
    random_image(9);
    run_frame(9, 3);
    random_image(6);
    run_frame(6, 3);
  endtask

  task automatic reset_mid_frame();
    random_kernel(3);
    write_kernel();
    random_image(8);
    @(negedge clk);
    img_size    = renkon_pkg::size_t'(8);
    fil_size    = renkon_pkg::size_t'(3);
    frame_start = 1'b1;
    pixel_in    = img[0];
    // far enough in that results are flowing.
    for (int k = 1; k < 40; k++) begin
      @(negedge clk);
      frame_start = 1'b0;
      pixel_in    = img[k];
    end
    xrst = 1'b0;
    repeat (4) @(negedge clk);
    xrst = 1'b1;
    for (int k = 0; k < 50; k++) begin
      @(negedge clk);
      if (conv_valid) begin
        stop_with_error("conv_valid went high after reset without a new frame");
      end
    end
    // weights were cleared by reset.
    random_kernel(0);
    random_image(8);
    run_frame(8, 3);
  endtask

  initial begin
    void'($urandom(32'h1ee7_2cf0));
    xrst        = 1'b0;
    frame_start = 1'b0;
    img_size    = '0;
    fil_size    = '0;
    pixel_in    = '0;
    w_we        = 1'b0;
    w_addr      = '0;
    w_data      = '0;
    repeat (4) @(negedge clk);
    xrst = 1'b1;
    identity_kernel();
    random_3x3();
    extreme_5x5();
    back_to_back();
    reset_mid_frame();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- test/renkon_asserts.sv
`timescale 1ns/100ps

module renkon_asserts (
  input logic clk,
  input logic xrst,
  input logic frame_start,
  input logic win_valid,
  input logic conv_valid,
  input logic frame_done
);

  // cycles since frame_done saturate at 3.
  logic [1:0] idle_count;

  always_ff @(posedge clk) begin
    if (!xrst || frame_start) begin
      idle_count <= '0;
    end else if (frame_done) begin
      idle_count <= 2'd1;
    end else if (idle_count != 2'd0 && idle_count != 2'd3) begin
      idle_count <= idle_count + 1'b1;
    end
  end

  // --------------------
  // control outputs.
  // --------------------
  reset_outputs_low: assert property (@(posedge clk) !xrst |=> !conv_valid && !frame_done)
    else $error("conv_valid or frame_done high during reset");

  frame_done_single: assert property (@(posedge clk) disable iff (!xrst)
    frame_done |=> !frame_done)
    else $error("frame_done longer than one cycle");

  conv_follows_win: assert property (@(posedge clk) disable iff (!xrst)
    $past(win_valid, 2) && $past(xrst, 2) && $past(xrst, 1) |-> conv_valid)
    else $error("conv_valid missing 2 cycles after win_valid");

  no_late_conv: assert property (@(posedge clk) disable iff (!xrst)
    idle_count == 2'd3 |-> !conv_valid)
    else $error("conv_valid 3 or more cycles after frame_done");

endmodule

bind renkon_top renkon_asserts u_asserts (
  .clk         (clk),
  .xrst        (xrst),
  .frame_start (frame_start),
  .win_valid   (win_valid),
  .conv_valid  (conv_valid),
  .frame_done  (frame_done)
);

//--- hw/renkon_top.sv
`timescale 1ns/100ps

module renkon_top (
  input  logic                clk,
  input  logic                xrst,
  input  logic                frame_start,
  input  renkon_pkg::size_t   img_size,
  input  renkon_pkg::size_t   fil_size,
  input  renkon_pkg::pixel_t  pixel_in,
  input  logic                w_we,
  input  logic [4:0]          w_addr,
  input  renkon_pkg::weight_t w_data,
  output renkon_pkg::sum_t    conv_out,
  output logic                conv_valid,
  output logic                frame_done
);

  renkon_pkg::pixel_t window [renkon_pkg::NTAP-1:0];
  logic               win_valid;
  logic               frame_end;

  renkon_linebuf u_linebuf (
    .clk       (clk),
    .xrst      (xrst),
    .buf_en    (frame_start),
    .img_size  (img_size),
    .fil_size  (fil_size),
    .buf_input (pixel_in),
    .window    (window),
    .win_valid (win_valid),
    .frame_end (frame_end)
  );

  renkon_conv u_conv (
    .clk        (clk),
    .xrst       (xrst),
    .w_we       (w_we),
    .w_addr     (w_addr),
    .w_data     (w_data),
    .window     (window),
    .win_valid  (win_valid),
    .conv_out   (conv_out),
    .conv_valid (conv_valid)
  );

  assign frame_done = frame_end;

endmodule

//--- hw/renkon_conv.sv
`timescale 1ns/100ps

module renkon_conv (
  input  logic                clk,
  input  logic                xrst,
  input  logic                w_we,
  input  logic [4:0]          w_addr,
  input  renkon_pkg::weight_t w_data,
  input  renkon_pkg::pixel_t  window [renkon_pkg::NTAP-1:0],
  input  logic                win_valid,
  output renkon_pkg::sum_t    conv_out,
  output logic                conv_valid
);

  renkon_pkg::weight_t r_weight [renkon_pkg::NTAP-1:0];
  renkon_pkg::prod_t   r_prod [renkon_pkg::NTAP-1:0];
  logic                r_valid_s1;

  // pairwise reduction over leaves padded to a power of two.
  function automatic renkon_pkg::sum_t tree_sum(
    input renkon_pkg::prod_t p [renkon_pkg::NTAP-1:0]
  );
    renkon_pkg::sum_t node [renkon_pkg::NLEAF-1:0];
    for (int i = 0; i < renkon_pkg::NLEAF; i++) begin
      node[i] = '0;
    end
    for (int i = 0; i < renkon_pkg::NTAP; i++) begin
      node[i] = p[i];
    end
    for (int w = renkon_pkg::NLEAF / 2; w > 0; w = w / 2) begin
      for (int i = 0; i < w; i++) begin
        node[i] = node[2*i] + node[2*i+1];
      end
    end
    return node[0];
  endfunction

  // --------------------
  // kernel registers.
  // --------------------
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < renkon_pkg::NTAP; i++) begin
        r_weight[i] <= '0;
      end
    end else if (w_we && w_addr < renkon_pkg::NTAP) begin
      r_weight[w_addr] <= w_data;
    end
  end

  // --------------------
  // multiply and sum.
  // --------------------
  always_ff @(posedge clk) begin
    for (int i = 0; i < renkon_pkg::NTAP; i++) begin
      r_prod[i] <= window[i] * r_weight[i];
    end
    conv_out <= tree_sum(r_prod);
  end

  // valid walks with its window.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_valid_s1 <= 1'b0;
      conv_valid <= 1'b0;
    end else begin
      r_valid_s1 <= win_valid;
      conv_valid <= r_valid_s1;
    end
  end

endmodule

//--- hw/renkon_linebuf.sv
`timescale 1ns/100ps

module renkon_linebuf (
  input  logic               clk,
  input  logic               xrst,
  input  logic               buf_en,
  input  renkon_pkg::size_t  img_size,
  input  renkon_pkg::size_t  fil_size,
  input  renkon_pkg::pixel_t buf_input,
  output renkon_pkg::pixel_t window [renkon_pkg::NTAP-1:0],
  output logic               win_valid,
  output logic               frame_end
);

  enum logic [1:0] {S_WAIT, S_CHARGE, S_ACTIVE} r_state;

  renkon_pkg::size_t         r_addr_count;
  renkon_pkg::size_t         r_line_count;
  renkon_pkg::size_t         r_mem_count;
  renkon_pkg::pixel_t        r_buf_input;
  renkon_pkg::pixel_t        read_mem [renkon_pkg::NMEM-1:0];
  logic [renkon_pkg::NMEM-1:0] mem_we;
  logic [renkon_pkg::MSWIDTH-1:0] row_sel [renkon_pkg::MAXLINE-1:0];

  logic                      s_line_end;
  logic                      s_charge_end;
  logic                      s_read;
  logic                      s_feed;
  logic                      s_write;
  logic                      s_data_end;
  renkon_pkg::size_t         s_rd_base;

  // read stage tags trail the counters by one cycle.
  renkon_pkg::size_t         r_col_s1;
  renkon_pkg::size_t         r_base_s1;
  logic                      r_rd_s1;
  logic                      r_last_s1;
  logic                      r_last_s2;

  // --------------------
  // control.
  // --------------------
  assign s_line_end   = r_addr_count == img_size - 1'b1;
  assign s_charge_end = r_line_count == fil_size - 1'b1 && s_line_end;
  // one extra line in the active state reads out the bottom window row.
  assign s_read       = r_state == S_ACTIVE && r_line_count <= img_size;
  assign s_feed       = r_state == S_CHARGE || s_read;
  assign s_write      = s_feed && r_line_count < img_size;
  assign s_data_end   = s_read && r_line_count == img_size && s_line_end;
  assign frame_end    = r_state == S_ACTIVE && r_last_s2;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state <= S_WAIT;
    end else begin
      case (r_state)
        S_WAIT: begin
          if (buf_en) begin
            r_state <= S_CHARGE;
          end
        end
        S_CHARGE: begin
          if (s_charge_end) begin
            r_state <= S_ACTIVE;
          end
        end
        S_ACTIVE: begin
          // wait for the last window to leave the read pipe.
          if (r_last_s2) begin
            r_state <= S_WAIT;
          end
        end
        default: begin
          r_state <= S_WAIT;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    r_buf_input <= buf_input;
  end

  always_ff @(posedge clk) begin
    if (!xrst || r_state == S_WAIT) begin
      r_addr_count <= '0;
      r_line_count <= '0;
      r_mem_count  <= '0;
    end else if (s_feed) begin
      if (s_line_end) begin
        r_addr_count <= '0;
        r_line_count <= r_line_count + 1'b1;
        if (r_mem_count == renkon_pkg::MAXLINE) begin
          r_mem_count <= '0;
        end else begin
          r_mem_count <= r_mem_count + 1'b1;
        end
      end else begin
        r_addr_count <= r_addr_count + 1'b1;
      end
    end
  end

  // memory of the oldest row in the window.
  assign s_rd_base = (r_mem_count >= fil_size)
                   ? r_mem_count - fil_size
                   : r_mem_count + renkon_pkg::size_t'(renkon_pkg::NMEM) - fil_size;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_rd_s1   <= 1'b0;
      r_last_s1 <= 1'b0;
      r_last_s2 <= 1'b0;
      win_valid <= 1'b0;
    end else begin
      r_rd_s1   <= s_read;
      r_last_s1 <= s_data_end;
      r_last_s2 <= r_last_s1;
      win_valid <= r_rd_s1 && r_col_s1 >= fil_size - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    r_col_s1  <= r_addr_count;
    r_base_s1 <= s_rd_base;
  end

  // --------------------
  // window registers.
  // --------------------
  for (genvar r = 0; r < renkon_pkg::MAXLINE; r++) begin : g_row
    renkon_pkg::size_t row_sum;
    renkon_pkg::size_t row_fix;

    assign row_sum = r_base_s1 + renkon_pkg::size_t'(r);
    assign row_fix = (row_sum >= renkon_pkg::NMEM)
                   ? row_sum - renkon_pkg::size_t'(renkon_pkg::NMEM)
                   : row_sum;
    assign row_sel[r] = row_fix[renkon_pkg::MSWIDTH-1:0];

    for (genvar c = 0; c < renkon_pkg::MAXLINE; c++) begin : g_col
      if (c == renkon_pkg::MAXLINE - 1) begin : g_load
        always_ff @(posedge clk) begin
          window[r*renkon_pkg::MAXLINE+c] <= read_mem[row_sel[r]];
        end
      end else begin : g_shift
        // new column enters at the filter's right edge.
        always_ff @(posedge clk) begin
          if (fil_size == c + 1) begin
            window[r*renkon_pkg::MAXLINE+c] <= read_mem[row_sel[r]];
          end else begin
            window[r*renkon_pkg::MAXLINE+c] <= window[r*renkon_pkg::MAXLINE+c+1];
          end
        end
      end
    end
  end

  // --------------------
  // line memories.
  // --------------------
  for (genvar i = 0; i < renkon_pkg::NMEM; i++) begin : g_mem
    assign mem_we[i] = s_write && r_mem_count == i;

    mem_sp #(
      .DATA_WIDTH (renkon_pkg::DWIDTH),
      .ADDR_WIDTH (renkon_pkg::ADDRW)
    ) u_mem (
      .clk        (clk),
      .mem_we     (mem_we[i]),
      .mem_addr   (r_addr_count[renkon_pkg::ADDRW-1:0]),
      .write_data (r_buf_input),
      .read_data  (read_mem[i])
    );
  end

endmodule

//--- hw/mem_sp.sv
`timescale 1ns/100ps

module mem_sp #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 5
) (
  input  logic                  clk,
  input  logic                  mem_we,
  input  logic [ADDR_WIDTH-1:0] mem_addr,
  input  logic [DATA_WIDTH-1:0] write_data,
  output logic [DATA_WIDTH-1:0] read_data
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  // read-before-write returns the old word on a write cycle.
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= write_data;
    end
    read_data <= mem[mem_addr];
  end

endmodule

//--- hw/renkon_pkg.sv
package renkon_pkg;

  // --------------------
  // data widths.
  // --------------------
  localparam int DWIDTH = 16;
  localparam int WWIDTH = 8;
  localparam int AWIDTH = 40;
  localparam int LWIDTH = 6;
  localparam int PWIDTH = DWIDTH + WWIDTH;

  // --------------------
  // window and image limits.
  // --------------------
  localparam int MAXLINE = 5;
  localparam int MAXSIZE = 32;
  localparam int NTAP = MAXLINE * MAXLINE;

  // one spare line memory is written while the others are read.
  localparam int NMEM = MAXLINE + 1;
  localparam int MSWIDTH = $clog2(NMEM);
  localparam int ADDRW = $clog2(MAXSIZE);
  localparam int NLEAF = 2 ** $clog2(NTAP);

  typedef logic signed [DWIDTH-1:0] pixel_t;
  typedef logic signed [WWIDTH-1:0] weight_t;
  typedef logic signed [PWIDTH-1:0] prod_t;
  typedef logic signed [AWIDTH-1:0] sum_t;
  typedef logic        [LWIDTH-1:0] size_t;

endpackage
